// File: common/mbu_consts.svh
// Memory bank unit constants for bank count, I/O window, address codes and defaults

`ifndef MBU_CONSTS_SVH
`define MBU_CONSTS_SVH

// Register file size
`define MBU_NUM_BANKS 8

// I/O window 0x08..0x0F, low three bits pick the register
`define MBU_IO_BASE 8'h08

// Control unit read address codes
`define MBU_RADDR_MBP       5'b01100
`define MBU_RADDR_MBP_FLAGS 5'b01101
`define MBU_RADDR_FLAGS     5'b01110

// Control unit write address codes, same values as the reads
`define MBU_WADDR_MBP       5'b01100
`define MBU_WADDR_MBP_FLAGS 5'b01101
`define MBU_WADDR_FLAGS     5'b01110

// Prefix of the four AR write codes 001xx
`define MBU_WADDR_AR_MBX_HI 3'b001

// Power-on bank bytes
`define MBU_ROM_BANK 8'h80  // Front panel ROM switch set
`define MBU_RAM_BANK 8'h00  // ROM switch clear

`endif

// File: common/mbu_pkg.sv
// Memory bank unit package with the command, operation and flag strobe types

`default_nettype none

package mbu_pkg;

   ////////////////////
   // Operations
   ////////////////////

   // One command per cycle, listed here in decode priority order
   typedef enum logic [2:0] {
      MBU_OP_NONE     = 3'd0,  // Idle cycle
      MBU_OP_IO_WRITE = 3'd1,  // OUT to 0x08..0x0F
      MBU_OP_CU_WRITE = 3'd2,  // Control unit write to MBP
      MBU_OP_AR_LOAD  = 3'd3,  // AR load, bank byte goes to aext
      MBU_OP_IO_READ  = 3'd4,  // IN from 0x08..0x0F
      MBU_OP_CU_READ  = 3'd5   // Control unit read of MBP
   } mbu_op_e;

   ////////////////////
   // Command
   ////////////////////

   // Broadcast from the decoder to every slice and the output selector
   typedef struct packed {
      mbu_op_e    op;     // What to do this cycle
      logic [2:0] sel;    // Bank register index
      logic [7:0] wdata;  // Write data, zero when not a write
   } mbu_cmd_t;

   ////////////////////
   // Flag unit
   ////////////////////

   // Active high strobes, one per flag read or write address code
   typedef struct packed {
      logic read_flags;
      logic read_mbp_flags;
      logic write_flags;
      logic write_mbp_flags;
   } mbu_flag_strb_t;

endpackage : mbu_pkg

`default_nettype wire

// File: source/mbu_decode.sv
// Memory bank unit decoder, builds one command per cycle, flag strobes and the enable bit

`timescale 1ns/1ps
`default_nettype none

`include "mbu_consts.svh"

module mbu_decode (
   input  wire                          clk3,
   input  wire                          rst_n,
   input  wire  [7:0]                   ab,        // Address bus, low byte
   input  wire                          sysdev,    // I/O space select
   input  wire                          rd,        // I/O read level
   input  wire                          wr,        // I/O write level
   input  wire  [7:0]                   db_in,     // OUT data
   input  wire  [7:0]                   ibus_in,   // Control unit write data
   input  wire  [4:0]                   raddr,
   input  wire  [4:0]                   waddr,
   input  wire  [2:0]                   ir,        // Register index from IR
   input  wire                          idxen,     // Index AR load by ir
   output mbu_pkg::mbu_cmd_t            cmd,
   output logic                         enabled,   // Register file live
   output mbu_pkg::mbu_flag_strb_t      flag_strb
);
   import mbu_pkg::*;

   localparam logic [7:0] IO_BASE = `MBU_IO_BASE;

   logic io_hit;    // ab inside 0x08..0x0F on I/O space
   logic io_write;
   logic cu_write;
   logic ar_load;
   logic io_read;
   logic cu_read;

   ////////////////////
   // Address decode
   ////////////////////

   assign io_hit   = sysdev && (ab[7:3] == IO_BASE[7:3]);
   assign io_write = io_hit && wr;
   assign io_read  = io_hit && rd;
   assign cu_write = (waddr == `MBU_WADDR_MBP);
   assign cu_read  = (raddr == `MBU_RADDR_MBP);
   assign ar_load  = (waddr[4:2] == `MBU_WADDR_AR_MBX_HI);  // Any of 001xx

   ////////////////////
   // Command select
   ////////////////////

   // Fixed priority, first match wins
   always_comb begin
      cmd.op    = MBU_OP_NONE;
      cmd.sel   = 3'd0;
      cmd.wdata = 8'h00;
      if (io_write) begin
         cmd.op    = MBU_OP_IO_WRITE;
         cmd.sel   = ab[2:0];
         cmd.wdata = db_in;
      end else if (cu_write) begin
         cmd.op    = MBU_OP_CU_WRITE;
         cmd.sel   = ir;
         cmd.wdata = ibus_in;
      end else if (ar_load) begin
         cmd.op    = MBU_OP_AR_LOAD;
         cmd.sel   = idxen ? ir : {1'b0, waddr[1:0]};  // Indexed or fixed MB0..MB3
      end else if (io_read) begin
         cmd.op    = MBU_OP_IO_READ;
         cmd.sel   = ab[2:0];
      end else if (cu_read) begin
         cmd.op    = MBU_OP_CU_READ;
         cmd.sel   = ir;
      end
   end

   // Flag unit strobes, independent of the command above
   assign flag_strb.read_flags      = (raddr == `MBU_RADDR_FLAGS);
   assign flag_strb.read_mbp_flags  = (raddr == `MBU_RADDR_MBP_FLAGS);
   assign flag_strb.write_flags     = (waddr == `MBU_WADDR_FLAGS);
   assign flag_strb.write_mbp_flags = (waddr == `MBU_WADDR_MBP_FLAGS);

   ////////////////////
   // Enable flip-flop
   ////////////////////

   // Set by the first OUT to the unit, cleared only by reset
   always_ff @(posedge clk3 or negedge rst_n) begin
      if (!rst_n) begin
         enabled <= 1'b0;
      end else if (cmd.op == MBU_OP_IO_WRITE) begin
         enabled <= 1'b1;
      end
   end

endmodule : mbu_decode

`default_nettype wire

// File: mbu/mbu_bank_slice.sv
// Memory bank slice, one bank register with index match, write and power-on default

`timescale 1ns/1ps
`default_nettype none

`include "mbu_consts.svh"

module mbu_bank_slice #(
   parameter int unsigned INDEX = 0  // Register number, 0..7
) (
   input  wire                clk3,
   input  wire                rst_n,
   input  wire mbu_pkg::mbu_cmd_t cmd,       // Broadcast command
   input  wire                enabled,   // Register file live
   input  wire                fprom,     // Front panel ROM switch
   output logic [7:0]         val        // Value seen by the selector
);
   import mbu_pkg::*;

   localparam logic [2:0] SEL_ID = 3'(INDEX);

   logic       hit;       // This slice addressed
   logic       wr_en;
   logic [7:0] store_q;   // Stored bank byte
   logic [7:0] dflt;      // Power-on byte

   ////////////////////
   // Write
   ////////////////////

   assign hit   = (cmd.sel == SEL_ID);
   assign wr_en = hit && ((cmd.op == MBU_OP_IO_WRITE) || (cmd.op == MBU_OP_CU_WRITE));

   always_ff @(posedge clk3 or negedge rst_n) begin
      if (!rst_n) begin
         store_q <= 8'h00;          // Unwritten registers read zero once enabled
      end else if (wr_en) begin
         store_q <= cmd.wdata;
      end
   end

   ////////////////////
   // Read value
   ////////////////////

   // Until the file is enabled every slice shows the switch default
   assign dflt = fprom ? `MBU_ROM_BANK : `MBU_RAM_BANK;
   assign val  = enabled ? store_q : dflt;

endmodule : mbu_bank_slice

`default_nettype wire

// File: source/mbu_out_select.sv
// Memory bank output selector, drives bus read data and the registered address extension

`timescale 1ns/1ps
`default_nettype none

`include "mbu_consts.svh"

module mbu_out_select (
   input  wire                              clk3,
   input  wire                              rst_n,
   input  wire mbu_pkg::mbu_cmd_t           cmd,
   input  wire  [`MBU_NUM_BANKS*8-1:0]      bank_vals,  // Slice i in bits 8i+7..8i
   output logic [7:0]                       db_out,     // IN data
   output logic                             db_oe,
   output logic [7:0]                       ibus_out,   // Control unit read data
   output logic                             ibus_oe,
   output logic [7:0]                       aext        // Latched bank byte
);
   import mbu_pkg::*;

   logic [7:0] pick;      // Value of the addressed slice
   logic       io_rd;
   logic       cu_rd;

   ////////////////////
   // Slice mux
   ////////////////////

   assign pick = bank_vals[cmd.sel*8 +: 8];

   assign io_rd = (cmd.op == MBU_OP_IO_READ);
   assign cu_rd = (cmd.op == MBU_OP_CU_READ);

   ////////////////////
   // Bus drivers
   ////////////////////

   // Only one of the two reads can be decoded per cycle
   assign db_oe    = io_rd;
   assign db_out   = io_rd ? pick : 8'h00;   // Quiet when not driving
   assign ibus_oe  = cu_rd;
   assign ibus_out = cu_rd ? pick : 8'h00;

   ////////////////////
   // Address extension
   ////////////////////

   // Loaded with the AR, feeds ar[23:16]
   always_ff @(posedge clk3 or negedge rst_n) begin
      if (!rst_n) begin
         aext <= 8'h00;
      end else if (cmd.op == MBU_OP_AR_LOAD) begin
         aext <= pick;
      end
   end

endmodule : mbu_out_select

`default_nettype wire

// File: source/mbu_top.sv
// Memory bank unit top level, decoder feeding eight bank slices and the output selector

`timescale 1ns/1ps
`default_nettype none

`include "mbu_consts.svh"

module mbu_top (
   input  wire                          clk3,
   input  wire                          rst_n,
   input  wire  [7:0]                   ab,
   input  wire                          sysdev,
   input  wire                          rd,
   input  wire                          wr,
   input  wire  [7:0]                   db_in,
   output logic [7:0]                   db_out,
   output logic                         db_oe,
   input  wire  [7:0]                   ibus_in,
   output logic [7:0]                   ibus_out,
   output logic                         ibus_oe,
   input  wire  [4:0]                   raddr,
   input  wire  [4:0]                   waddr,
   input  wire  [2:0]                   ir,
   input  wire                          idxen,
   input  wire                          fprom,      // ROM switch
   output logic [7:0]                   aext,       // Address extension byte
   output mbu_pkg::mbu_flag_strb_t      flag_strb
);
   import mbu_pkg::*;

   mbu_cmd_t                   cmd;        // One command per cycle
   logic                       enabled;
   logic [`MBU_NUM_BANKS*8-1:0] bank_vals;  // All slice values
   logic [7:0]                 aext_q;     // Registered AR byte

   ////////////////////
   // Decode
   ////////////////////

   mbu_decode u_decode (
      .clk3      (clk3),
      .rst_n     (rst_n),
      .ab        (ab),
      .sysdev    (sysdev),
      .rd        (rd),
      .wr        (wr),
      .db_in     (db_in),
      .ibus_in   (ibus_in),
      .raddr     (raddr),
      .waddr     (waddr),
      .ir        (ir),
      .idxen     (idxen),
      .cmd       (cmd),
      .enabled   (enabled),
      .flag_strb (flag_strb)
   );

   ////////////////////
   // Register file
   ////////////////////

   for (genvar i = 0; i < `MBU_NUM_BANKS; i++) begin : g_bank
      mbu_bank_slice #(.INDEX(i)) u_slice (
         .clk3    (clk3),
         .rst_n   (rst_n),
         .cmd     (cmd),
         .enabled (enabled),
         .fprom   (fprom),
         .val     (bank_vals[i*8 +: 8])
      );
   end

   ////////////////////
   // Outputs
   ////////////////////

   mbu_out_select u_out_select (
      .clk3      (clk3),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .bank_vals (bank_vals),
      .db_out    (db_out),
      .db_oe     (db_oe),
      .ibus_out  (ibus_out),
      .ibus_oe   (ibus_oe),
      .aext      (aext_q)
   );

   // Power-on default on aext until the file comes up
   // An AR load before that latches the same default byte
   assign aext = enabled ? aext_q : (fprom ? `MBU_ROM_BANK : `MBU_RAM_BANK);

endmodule : mbu_top

`default_nettype wire

// File: sim/mbu_tb_clk.sv
// Testbench clock and power-on reset generator for the memory bank unit

`timescale 1ns/1ps
`default_nettype none

module mbu_tb_clk #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released on a falling edge, away from the DUT's active edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule : mbu_tb_clk

`default_nettype wire

// File: sim/mbu_assert.sv
// Memory bank unit assertions on bus enables and the address extension byte

`timescale 1ns/1ps
`default_nettype none

module mbu_assert (
   input wire              clk3,
   input wire              rst_n,
   input wire              db_oe,
   input wire              ibus_oe,
   input wire  [7:0]       aext,
   input mbu_pkg::mbu_op_e op,       // Decoded command of the cycle
   input wire              enabled   // Register file live
);
   import mbu_pkg::*;

   ////////////////////
   // Bus enables
   ////////////////////

   // One read per cycle, so never both buses
   a_oe_exclusive : assert property (@(posedge clk3) disable iff (!rst_n)
      !(db_oe && ibus_oe))
      else $error("db_oe and ibus_oe are high in the same cycle");

   a_oe_reset : assert property (@(posedge clk3) !rst_n |-> (!db_oe && !ibus_oe))
      else $error("bus enable high while in reset");

   ////////////////////
   // Address extension
   ////////////////////

   // Before enable aext follows the ROM switch and the enable itself swaps in the register
   a_aext_hold : assert property (@(posedge clk3) disable iff (!rst_n)
      (aext != $past(aext)) |-> (($past(op) == MBU_OP_AR_LOAD) || !$past(enabled)))
      else $error("aext changed without an AR load");

endmodule : mbu_assert

`default_nettype wire

// File: sim/mbu_tb.sv
// Memory bank unit testbench, directed and random rows checked against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "mbu_consts.svh"

module mbu_tb;
   import mbu_pkg::*;

   localparam int         PERIOD_NS    = 8;
   localparam int         RESET_CYCLES = 2;
   localparam int         NUM_RANDOM   = 40;
   localparam logic [7:0] IO_BASE      = `MBU_IO_BASE;

   typedef struct {
      string      name;
      logic       sysdev;
      logic       rd;
      logic       wr;
      logic [7:0] ab;
      logic [7:0] db_in;
      logic [7:0] ibus_in;
      logic [4:0] raddr;
      logic [4:0] waddr;
      logic [2:0] ir;
      logic       idxen;
      logic       fprom;
      logic       use_model;    // Expected values come from the model
      logic       exp_db_oe;
      logic [7:0] exp_db;
      logic       exp_ibus_oe;
      logic [7:0] exp_ibus;
      logic [7:0] exp_aext;     // Value after the row's clock edge
      logic [3:0] exp_flags;    // read, read_mbp, write, write_mbp
   } row_t;

   logic clk3, rst_n, sysdev, rd, wr, db_oe, ibus_oe, idxen, fprom;
   logic [7:0] ab, db_in, db_out, ibus_in, ibus_out, aext;
   logic [4:0] raddr, waddr;
   logic [2:0] ir;
   mbu_flag_strb_t flag_strb;

   row_t       rows[$];
   logic       table_ready = 1'b0;
   logic       cur_fprom;          // Switch level for directed rows being built
   logic [7:0] cur_aext;           // Expected aext while building directed rows
   int         seed = 13092;
   int         num_checks = 0;
   int         num_errors = 0;
   logic [7:0] m_bank [8];         // Reference bank registers
   logic       m_en;
   logic [7:0] m_aext_q;

   mbu_tb_clk #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk (
      .clk   (clk3),
      .rst_n (rst_n)
   );

   mbu_top u_dut (.*);

   bind mbu_top mbu_assert u_assert (
      .clk3    (clk3),
      .rst_n   (rst_n),
      .db_oe   (db_oe),
      .ibus_oe (ibus_oe),
      .aext    (aext),
      .op      (cmd.op),
      .enabled (enabled)
   );

   ////////////////////
   // Table rows
   ////////////////////

   function automatic row_t idle_row(input string name);
      row_t r;
      r = '{name: name, fprom: cur_fprom, exp_aext: cur_aext, default: '0};
      return r;
   endfunction

   task automatic io_read_row(input string name, input logic [2:0] idx, input logic [7:0] exp);
      row_t r;
      r = idle_row(name);
      r.sysdev    = 1'b1;
      r.rd        = 1'b1;
      r.ab        = IO_BASE | {5'b0, idx};
      r.exp_db_oe = 1'b1;
      r.exp_db    = exp;
      rows.push_back(r);
   endtask

   task automatic cu_read_row(input string name, input logic [2:0] idx, input logic [7:0] exp);
      row_t r;
      r = idle_row(name);
      r.raddr       = `MBU_RADDR_MBP;
      r.ir          = idx;
      r.exp_ibus_oe = 1'b1;
      r.exp_ibus    = exp;
      rows.push_back(r);
   endtask

   task automatic io_write_row(input string name, input logic [2:0] idx, input logic [7:0] d);
      row_t r;
      r = idle_row(name);
      r.sysdev = 1'b1;
      r.wr     = 1'b1;
      r.ab     = IO_BASE | {5'b0, idx};
      r.db_in  = d;
      rows.push_back(r);
   endtask

   task automatic cu_write_row(input string name, input logic [2:0] idx, input logic [7:0] d);
      row_t r;
      r = idle_row(name);
      r.waddr   = `MBU_WADDR_MBP;
      r.ir      = idx;
      r.ibus_in = d;
      rows.push_back(r);
   endtask

   // New aext value is known from the rule, held by later rows
   task automatic ar_load_row(input string name, input logic [1:0] lo, input logic [2:0] idx,
                              input logic idx_en, input logic [7:0] exp);
      row_t r;
      cur_aext = exp;
      r = idle_row(name);
      r.waddr = {`MBU_WADDR_AR_MBX_HI, lo};
      r.ir    = idx;
      r.idxen = idx_en;
      rows.push_back(r);
   endtask

   task automatic flag_row(input string name, input logic [4:0] ra, input logic [4:0] wa,
                           input logic [3:0] exp);
      row_t r;
      r = idle_row(name);
      r.raddr     = ra;
      r.waddr     = wa;
      r.exp_flags = exp;
      rows.push_back(r);
   endtask

   // Mixed and overlapping commands, expected values filled in at run time
   task automatic random_row(input int n);
      row_t        r;
      logic [31:0] a;
      logic [31:0] b;
      r = idle_row($sformatf("random_%0d", n));
      a = $random(seed);
      b = $random(seed);
      r.use_model = 1'b1;
      r.sysdev    = a[0];
      r.rd        = a[1];
      r.wr        = a[2] & a[3];                               // Fewer writes than reads
      r.ab        = a[4] ? {IO_BASE[7:3], a[7:5]} : a[15:8];   // Mostly in the window
      r.db_in     = a[23:16];
      r.ibus_in   = b[7:0];
      r.ir        = b[10:8];
      r.idxen     = b[11];
      r.fprom     = b[12];
      case (b[15:13])
         3'd0:       r.waddr = `MBU_WADDR_MBP;
         3'd1, 3'd2: r.waddr = {`MBU_WADDR_AR_MBX_HI, b[17:16]};
         3'd3:       r.waddr = `MBU_WADDR_FLAGS;
         3'd4:       r.waddr = `MBU_WADDR_MBP_FLAGS;
         default:    r.waddr = b[22:18];
      endcase
      case (b[25:23])
         3'd0, 3'd1: r.raddr = `MBU_RADDR_MBP;
         3'd2:       r.raddr = `MBU_RADDR_FLAGS;
         3'd3:       r.raddr = `MBU_RADDR_MBP_FLAGS;
         default:    r.raddr = b[30:26];
      endcase
      rows.push_back(r);
   endtask

   task automatic build_table();
      row_t r;
      cur_fprom = 1'b0;   // Power-on defaults, switch clear then set
      cur_aext  = `MBU_RAM_BANK;
      for (int i = 0; i < 8; i++) begin
         io_read_row($sformatf("default_ram_io_mb%0d", i), 3'(i), `MBU_RAM_BANK);
         cu_read_row($sformatf("default_ram_cu_mb%0d", i), 3'(i), `MBU_RAM_BANK);
      end
      cur_fprom = 1'b1;
      cur_aext  = `MBU_ROM_BANK;
      for (int i = 0; i < 8; i++) begin
         io_read_row($sformatf("default_rom_io_mb%0d", i), 3'(i), `MBU_ROM_BANK);
         cu_read_row($sformatf("default_rom_cu_mb%0d", i), 3'(i), `MBU_ROM_BANK);
      end
      cur_aext = 8'h00;   // Enabled file shows the AR byte, still at reset
      io_write_row("enable_write_mb3", 3'd3, 8'h5A);
      for (int i = 0; i < 8; i++)
         io_read_row($sformatf("enabled_io_mb%0d", i), 3'(i), (i == 3) ? 8'h5A : 8'h00);
      cu_write_row("cu_write_mb5", 3'd5, 8'hC3);
      io_read_row("io_read_mb5", 3'd5, 8'hC3);
      io_write_row("io_write_mb0", 3'd0, 8'h11);
      io_write_row("io_write_mb6", 3'd6, 8'hE7);
      cu_read_row("cu_read_mb0", 3'd0, 8'h11);
      cu_read_row("cu_read_mb6", 3'd6, 8'hE7);
      ar_load_row("ar_load_fixed_mb3", 2'd3, 3'd5, 1'b0, 8'h5A);   // ir ignored
      flag_row("ar_hold_1", 5'd0, 5'd0, 4'b0000);
      flag_row("ar_hold_2", 5'd0, 5'd0, 4'b0000);
      ar_load_row("ar_load_indexed_mb5", 2'd0, 3'd5, 1'b1, 8'hC3);
      flag_row("ar_hold_3", 5'd0, 5'd0, 4'b0000);
      io_read_row("ar_hold_io_read", 3'd0, 8'h11);
      flag_row("flag_read", `MBU_RADDR_FLAGS, 5'd0, 4'b1000);
      flag_row("flag_read_mbp", `MBU_RADDR_MBP_FLAGS, 5'd0, 4'b0100);
      flag_row("flag_write", 5'd0, `MBU_WADDR_FLAGS, 4'b0010);
      flag_row("flag_write_mbp", 5'd0, `MBU_WADDR_MBP_FLAGS, 4'b0001);
      r = idle_row("priority_io_over_cu");   // I/O write beats control unit write
      r.sysdev  = 1'b1;
      r.wr      = 1'b1;
      r.ab      = IO_BASE | 8'h04;
      r.db_in   = 8'h3C;
      r.waddr   = `MBU_WADDR_MBP;
      r.ir      = 3'd4;
      r.ibus_in = 8'h99;
      rows.push_back(r);
      io_read_row("priority_io_mb4", 3'd4, 8'h3C);
      cu_read_row("priority_cu_mb4", 3'd4, 8'h3C);
      for (int n = 0; n < NUM_RANDOM; n++)
         random_row(n);
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Priority order and timing as in the unit spec, state updated for the row's edge
   task automatic model_step(input row_t r, output row_t p);
      logic       in_win;
      logic [7:0] dflt;
      logic [2:0] sel;
      p = r;
      p.exp_db_oe   = 1'b0;
      p.exp_db      = 8'h00;
      p.exp_ibus_oe = 1'b0;
      p.exp_ibus    = 8'h00;
      in_win = r.sysdev && (r.ab[7:3] == IO_BASE[7:3]);
      dflt   = r.fprom ? `MBU_ROM_BANK : `MBU_RAM_BANK;
      p.exp_flags = {r.raddr == `MBU_RADDR_FLAGS, r.raddr == `MBU_RADDR_MBP_FLAGS,
                     r.waddr == `MBU_WADDR_FLAGS, r.waddr == `MBU_WADDR_MBP_FLAGS};
      if (in_win && r.wr) begin
         m_bank[r.ab[2:0]] = r.db_in;
         m_en = 1'b1;
      end else if (r.waddr == `MBU_WADDR_MBP) begin
         m_bank[r.ir] = r.ibus_in;
      end else if (r.waddr[4:2] == `MBU_WADDR_AR_MBX_HI) begin
         sel      = r.idxen ? r.ir : {1'b0, r.waddr[1:0]};
         m_aext_q = m_en ? m_bank[sel] : dflt;
      end else if (in_win && r.rd) begin
         p.exp_db_oe = 1'b1;
         p.exp_db    = m_en ? m_bank[r.ab[2:0]] : dflt;
      end else if (r.raddr == `MBU_RADDR_MBP) begin
         p.exp_ibus_oe = 1'b1;
         p.exp_ibus    = m_en ? m_bank[r.ir] : dflt;
      end
      p.exp_aext = m_en ? m_aext_q : dflt;
   endtask

   ////////////////////
   // Drive and check
   ////////////////////

   task automatic drive_inputs(input row_t r);
      sysdev  = r.sysdev;
      rd      = r.rd;
      wr      = r.wr;
      ab      = r.ab;
      db_in   = r.db_in;
      ibus_in = r.ibus_in;
      raddr   = r.raddr;
      waddr   = r.waddr;
      ir      = r.ir;
      idxen   = r.idxen;
      fprom   = r.fprom;
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [7:0] exp, input logic [7:0] act);
      num_checks++;
      if (exp !== act) begin
         num_errors++;
         $display("CHECK FAILED %s %s expected 0x%02h actual 0x%02h", name, what, exp, act);
      end
   endtask

   task automatic compare_outputs(input row_t e);
      check_value(e.name, "db_oe", {7'h00, e.exp_db_oe}, {7'h00, db_oe});
      if (e.exp_db_oe)
         check_value(e.name, "db_out", e.exp_db, db_out);   // Data only while driven
      check_value(e.name, "ibus_oe", {7'h00, e.exp_ibus_oe}, {7'h00, ibus_oe});
      if (e.exp_ibus_oe)
         check_value(e.name, "ibus_out", e.exp_ibus, ibus_out);
      check_value(e.name, "aext", e.exp_aext, aext);
      check_value(e.name, "flag_strb", {4'h0, e.exp_flags}, {4'h0, flag_strb});
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      row_t pred;
      row_t exp;
      sysdev  = 1'b0;
      rd      = 1'b0;
      wr      = 1'b0;
      ab      = 8'h00;
      db_in   = 8'h00;
      ibus_in = 8'h00;
      raddr   = 5'd0;
      waddr   = 5'd0;
      ir      = 3'd0;
      idxen   = 1'b0;
      fprom   = 1'b0;
      m_en     = 1'b0;
      m_aext_q = 8'h00;
      for (int k = 0; k < 8; k++)
         m_bank[k] = 8'h00;
      build_table();
      table_ready = 1'b1;
      wait (rst_n === 1'b1);
      @(negedge clk3);
      foreach (rows[i]) begin
         drive_inputs(rows[i]);
         model_step(rows[i], pred);
         if (rows[i].use_model)
            exp = pred;
         else
            exp = rows[i];
         @(negedge clk3);   // Sampled after the row's rising edge
         compare_outputs(exp);
      end
      $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), num_checks, num_errors);
      if (num_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog, one clock per row plus reset and a margin
   initial begin
      int limit_ns;
      wait (table_ready);
      limit_ns = (rows.size() + RESET_CYCLES + 4) * PERIOD_NS + 200;
      #(limit_ns);
      $display("Watchdog expired, the run did not finish within %0d ns", limit_ns);
      $display("TESTS FAILED");
      $finish;
   end

endmodule : mbu_tb

`default_nettype wire

// File: mbu.f
+incdir+common
common/mbu_pkg.sv
source/mbu_decode.sv
mbu/mbu_bank_slice.sv
source/mbu_out_select.sv
source/mbu_top.sv
sim/mbu_tb_clk.sv
sim/mbu_assert.sv
sim/mbu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory bank unit testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module mbu_tb -f mbu.f -o mbu_sim

# The log decides the result, an assertion stop leaves no pass line
./obj_dir/mbu_sim | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
   echo "Simulation reported failure, see $LOG"
   exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "Simulation ended without a result, see $LOG"
   exit 1
fi
echo "Simulation passed"
exit 0
